/* Makefile */
# Verilator build and run for the fetch stage 2 testbench.
VERILATOR ?= verilator
TOP       ?= tbFetchStage2
RTL_TOP   ?= FetchStage2
FILELIST  ?= fetchStage2.f
OBJ_DIR   ?= obj_dir
PASS_MSG  ?= ALL CHECKS PASSED
VFLAGS    ?= --binary --timing -Wno-fatal
LINTFLAGS ?= --lint-only -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	@out="$$($(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)

/* fetchStage2.f */
+incdir+source
source/fetchPkg.sv
source/ctiPkg.sv
source/PreDecode.sv
source/CtrlQueue.sv
source/FetchStage2.sv
sim/tbFetchStage2.sv

/* sim/tbFetchStage2.sv */
/*
 * Testbench for fetch stage 2. Applies a table of bundles through a reference
 * model of the decode rules, then checks commit updates and queue back-pressure.
 */
`include "fetch_params.svh"

module tbFetchStage2;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int PERIOD = 40;
  localparam int NUM_VEC = 8;

  // one table row; arrays are indexed by slot number.
  typedef struct packed {
    fetchPkg::pc_t        pc;
    logic [0:3][7:0]      op;
    logic [0:3][25:0]     imm;
    logic [0:3]           hit;
    logic [0:3]           pred;
    fetchPkg::pc_t        btbTgt;
    fetchPkg::pc_t        ras;
    logic                 stall;
    fetchPkg::fetchMask_t expMask;
  } bundleVec_t;

  logic clk;
  logic rst;
  logic stall;
  logic recoverFlag;
  logic fs1Ready;
  fetchPkg::pc_t fetchPc;
  fetchPkg::instruction_t [`FETCH_BANDWIDTH-1:0] bundle;
  fetchPkg::btbSlot_t [`FETCH_BANDWIDTH-1:0] btb;
  fetchPkg::pc_t rasAddr;
  ctiPkg::ctiqTag_t resolveIndex;
  fetchPkg::pc_t resolveTarget;
  logic resolveTaken;
  logic resolveValid;
  logic flagRecoverEX;
  logic commit;
  fetchPkg::fetchMask_t instValid;
  fetchPkg::instPacket_t [`FETCH_BANDWIDTH-1:0] instPacket;
  fetchPkg::idRedirect_t redirect;
  ctiPkg::btbUpdate_t btbUpdate;
  logic fs2Ready;
  logic queueFull;

  // reference copy of the control queue.
  fetchPkg::pc_t       mPc [`CTIQ_DEPTH];
  fetchPkg::ctrlType_t mType [`CTIQ_DEPTH];
  ctiPkg::ctiqTag_t    mHead;
  ctiPkg::ctiqTag_t    mTail;
  int                  mCount;
  bundleVec_t          vecs [NUM_VEC];
  string               names [NUM_VEC];
  bundleVec_t          fillVec;

  FetchStage2 dut (
    .clk(clk), .rst_i(rst), .stall_i(stall), .recoverFlag_i(recoverFlag),
    .fs1Ready_i(fs1Ready), .pc_i(fetchPc), .bundle_i(bundle), .btb_i(btb),
    .rasAddr_i(rasAddr), .resolveIndex_i(resolveIndex), .resolveTarget_i(resolveTarget),
    .resolveTaken_i(resolveTaken), .resolveValid_i(resolveValid),
    .flagRecoverEX_i(flagRecoverEX), .commit_i(commit), .instValid_o(instValid),
    .instPacket_o(instPacket), .redirect_o(redirect), .btbUpdate_o(btbUpdate),
    .fs2Ready_o(fs2Ready), .ctiQueueFull_o(queueFull)
  );

  always #(PERIOD/2) clk = ~clk;

  task automatic abortRun(string reason);
    $display("CHECKS FAILED");
    $fatal(1, "%s", reason);
  endtask

  task automatic checkMask(string name, fetchPkg::fetchMask_t exp, fetchPkg::fetchMask_t act);
    if (exp !== act) begin
      $display("ERR %s valid mask expected %b actual %b", name, exp, act);
      abortRun("valid mask mismatch");
    end
  endtask

  task automatic checkPacket(string name, fetchPkg::instPacket_t exp, fetchPkg::instPacket_t act);
    if (exp !== act) begin
      $display("ERR %s packet expected %h actual %h", name, exp, act);
      abortRun("instruction packet mismatch");
    end
  endtask

  task automatic checkRedirect(string name, fetchPkg::idRedirect_t exp,
                               fetchPkg::idRedirect_t act);
    if (exp !== act) begin
      $display("ERR %s redirect expected %h actual %h", name, exp, act);
      abortRun("redirect mismatch");
    end
  endtask

  task automatic checkUpdate(string name, ctiPkg::btbUpdate_t exp, ctiPkg::btbUpdate_t act);
    if (exp !== act) begin
      $display("ERR %s BTB update expected %h actual %h", name, exp, act);
      abortRun("BTB update mismatch");
    end
  endtask

  task automatic expectFlag(string name, string flag, logic exp, logic act);
    if (exp !== act) begin
      $display("ERR %s %s expected %b actual %b", name, flag, exp, act);
      abortRun("status flag mismatch");
    end
  endtask

  function automatic logic isCti(logic [7:0] op);
    return op inside {`OP_JUMP, `OP_CALL, `OP_RETURN, `OP_CBRANCH};
  endfunction

  function automatic fetchPkg::ctrlType_t typeOf(logic [7:0] op);
    case (op)
      `OP_RETURN:  return fetchPkg::CT_RETURN;
      `OP_CALL:    return fetchPkg::CT_CALL;
      `OP_CBRANCH: return fetchPkg::CT_CBRANCH;
      default:     return fetchPkg::CT_JUMP;
    endcase
  endfunction

  // opcode 0 in the table asks for a random non-CTI instruction.
  function automatic fetchPkg::instruction_t makeInst(logic [7:0] op, logic [25:0] imm);
    logic [7:0] opcode;
    opcode = (op == 8'h00) ? 8'(8'h08 + $urandom_range(239, 0)) : op;
    return {opcode, 30'($urandom), imm};
  endfunction

  task automatic predictBundle(input bundleVec_t v,
                               input fetchPkg::instruction_t [`FETCH_BANDWIDTH-1:0] insts,
                               output fetchPkg::fetchMask_t mask,
                               output fetchPkg::instPacket_t [`FETCH_BANDWIDTH-1:0] pkts,
                               output fetchPkg::idRedirect_t redir, output logic miss);
    fetchPkg::pc_t slotPc;
    fetchPkg::pc_t tgt;
    fetchPkg::ctrlType_t ty;
    logic ended;
    int pushed;
    ended = 1'b0;
    pushed = 0;
    mask = '0;
    redir = '0;
    miss = 1'b0;
    for (int s = 0; s < `FETCH_BANDWIDTH; s++) begin
      slotPc = v.pc + 32'(s * `INST_BYTES);
      ty = typeOf(v.op[s]);
      if (ty == fetchPkg::CT_RETURN) begin
        tgt = v.btbTgt + 32'(16 * s);
      end else if (ty == fetchPkg::CT_CBRANCH) begin
        tgt = slotPc + 32'd8 + (v.pred[s] ? 32'($signed(v.imm[s][15:0])) * 32'd8 : 32'd0);
      end else begin
        tgt = {slotPc[31:29], v.imm[s][25:0], 3'b000};
      end
      pkts[s] = '{instruction: insts[s], pc: slotPc, target: tgt,
                  ctiqTag: ctiPkg::ctiqTag_t'(32'(mTail) + pushed), prediction: v.pred[s]};
      if (!ended) begin
        mask[`FETCH_BANDWIDTH-1-s] = 1'b1;
        if (isCti(v.op[s])) pushed++;
        if (isCti(v.op[s]) && (v.pred[s] || ty != fetchPkg::CT_CBRANCH)) begin
          ended = 1'b1;
          if (!v.hit[s]) begin
            miss = 1'b1;
            redir = '{recover: 1'b1, isReturn: ty == fetchPkg::CT_RETURN,
                      isCall: ty == fetchPkg::CT_CALL, target: tgt, callPc: slotPc};
            if (ty == fetchPkg::CT_RETURN) begin
              redir.target = v.ras;
              pkts[s].target = v.ras;
            end
          end
        end
      end
    end
  endtask

  task automatic applyBundle(string name, bundleVec_t v);
    fetchPkg::instruction_t [`FETCH_BANDWIDTH-1:0] insts;
    fetchPkg::instPacket_t [`FETCH_BANDWIDTH-1:0] expPkt;
    fetchPkg::instPacket_t actPkt;
    fetchPkg::fetchMask_t expMask;
    fetchPkg::idRedirect_t expRedir;
    logic miss;
    logic expFull;
    expFull = mCount > (`CTIQ_DEPTH - `FETCH_BANDWIDTH);
    for (int s = 0; s < `FETCH_BANDWIDTH; s++) insts[s] = makeInst(v.op[s], v.imm[s]);
    @(negedge clk);
    fs1Ready = 1'b1;
    fetchPc = v.pc;
    bundle = insts;
    rasAddr = v.ras;
    stall = v.stall;
    for (int s = 0; s < `FETCH_BANDWIDTH; s++) begin
      btb[s] = '{hit: v.hit[s], target: v.btbTgt + 32'(16 * s), prediction: v.pred[s]};
    end
    predictBundle(v, insts, expMask, expPkt, expRedir, miss);
    #(PERIOD/4);
    checkMask(name, v.expMask, instValid);
    checkMask(name, expMask, instValid);
    for (int s = 0; s < `FETCH_BANDWIDTH; s++) begin
      actPkt = instPacket[s];
      // a non-CTI slot has no defined target.
      if (!isCti(v.op[s])) begin
        actPkt.target = '0;
        expPkt[s].target = '0;
      end
      checkPacket(name, expPkt[s], actPkt);
    end
    if (miss) begin
      expRedir.recover = !v.stall && !expFull;
      checkRedirect(name, expRedir, redirect);
    end else begin
      expectFlag(name, "recover", 1'b0, redirect.recover);
    end
    expectFlag(name, "full", expFull, queueFull);
    expectFlag(name, "fs2Ready", !expFull, fs2Ready);
    if (!v.stall && !expFull) begin
      for (int s = 0; s < `FETCH_BANDWIDTH; s++) begin
        if (expMask[`FETCH_BANDWIDTH-1-s] && isCti(v.op[s])) begin
          mPc[mTail] = expPkt[s].pc;
          mType[mTail] = typeOf(v.op[s]);
          mTail++;
          mCount++;
        end
      end
    end
  endtask

  task automatic retireHead(fetchPkg::pc_t target, logic taken);
    ctiPkg::btbUpdate_t expUpd;
    string name;
    name = $sformatf("retire%0d", mHead);
    @(negedge clk);
    resolveValid = 1'b1;
    resolveIndex = mHead;
    resolveTarget = target;
    resolveTaken = taken;
    @(negedge clk);
    resolveValid = 1'b0;
    commit = 1'b1;
    expUpd = '{en: 1'b1, pc: mPc[mHead], target: target, ctrlType: mType[mHead], dir: taken};
    @(negedge clk);
    commit = 1'b0;
    #(PERIOD/4);
    checkUpdate(name, expUpd, btbUpdate);
    mHead++;
    mCount--;
    @(negedge clk);
    #(PERIOD/4);
    expUpd.en = 1'b0;
    checkUpdate(name, expUpd, btbUpdate);
  endtask

  task automatic loadTable();
    names[0] = "noCti";
    vecs[0] = '{32'h1000, {8'h0, 8'h0, 8'h0, 8'h0}, '0, 4'b0000, 4'b0000,
                32'h9000, 32'h0, 1'b0, 4'b1111};
    names[1] = "jumpHit1";
    vecs[1] = '{32'h2000, {8'h0, `OP_JUMP, 8'h0, 8'h0}, {26'h0, 26'h100, 26'h0, 26'h0},
                4'b0100, 4'b0100, 32'h9100, 32'h0, 1'b0, 4'b1100};
    names[2] = "callMiss2";
    vecs[2] = '{32'h3000, {8'h0, 8'h0, `OP_CALL, 8'h0}, {26'h0, 26'h0, 26'h2040, 26'h0},
                4'b0000, 4'b0010, 32'h9200, 32'h0, 1'b0, 4'b1110};
    names[3] = "retMiss0";
    vecs[3] = '{32'h4000, {`OP_RETURN, 8'h0, 8'h0, 8'h0}, '0, 4'b0000, 4'b1000,
                32'h9300, 32'h6660, 1'b0, 4'b1000};
    names[4] = "brNotTaken";
    vecs[4] = '{32'h5000, {`OP_CBRANCH, `OP_CBRANCH, 8'h0, `OP_JUMP},
                {26'hfff0, 26'h0004, 26'h0, 26'h55}, 4'b1100, 4'b0100,
                32'h9400, 32'h0, 1'b0, 4'b1100};
    names[5] = "stallMiss";
    vecs[5] = '{32'h6000, {8'h0, `OP_JUMP, 8'h0, 8'h0}, {26'h0, 26'h300, 26'h0, 26'h0},
                4'b0000, 4'b0100, 32'h9500, 32'h0, 1'b1, 4'b1100};
    names[6] = "retHit3";
    vecs[6] = '{32'h7000, {8'h0, 8'h0, 8'h0, `OP_RETURN}, '0, 4'b0001, 4'b0001,
                32'h9600, 32'h7770, 1'b0, 4'b1111};
    names[7] = "brMiss";
    vecs[7] = '{32'h7800, {`OP_CBRANCH, 8'h0, 8'h0, 8'h0}, {26'h0010, 26'h0, 26'h0, 26'h0},
                4'b0000, 4'b1000, 32'h9700, 32'h0, 1'b0, 4'b1000};
    // four not-taken branches fill the queue a whole bundle at a time.
    fillVec = '{32'h8000, {4{`OP_CBRANCH}}, {26'h1, 26'h2, 26'h3, 26'h4}, 4'b1111, 4'b0000,
                32'h9800, 32'h0, 1'b0, 4'b1111};
  endtask

  // the run is bounded by twenty cycles per table row.
  initial begin
    #(NUM_VEC * 20 * PERIOD);
    $display("watchdog expired before the test sequence ended");
    $display("CHECKS FAILED");
    $fatal(1, "timeout");
  end

  initial begin
    void'($urandom(32'h4c70));
    clk = 1'b0;
    rst = 1'b1;
    stall = 1'b0;
    recoverFlag = 1'b0;
    fs1Ready = 1'b1;
    fetchPc = '0;
    bundle = '0;
    btb = '0;
    rasAddr = '0;
    resolveIndex = '0;
    resolveTarget = '0;
    resolveTaken = 1'b0;
    resolveValid = 1'b0;
    flagRecoverEX = 1'b0;
    commit = 1'b0;
    mHead = '0;
    mTail = '0;
    mCount = 0;
    loadTable();
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    for (int i = 0; i < NUM_VEC; i++) applyBundle(names[i], vecs[i]);
    @(negedge clk);
    fs1Ready = 1'b0;
    retireHead(32'h7000, 1'b1);
    retireHead(32'h7040, 1'b0);
    retireHead(32'h7080, 1'b1);
    while (mCount <= `CTIQ_DEPTH - `FETCH_BANDWIDTH) applyBundle("fill", fillVec);
    applyBundle("fullHold", fillVec);
    @(negedge clk);
    recoverFlag = 1'b1;
    fs1Ready = 1'b0;
    @(negedge clk);
    recoverFlag = 1'b0;
    mCount = 0;
    mTail = mHead;
    applyBundle("afterRecover", vecs[1]);
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

/* source/CtrlQueue.sv */
/*
 * Circular control queue. Valid CTIs of a bundle are tagged in order, execute
 * writes their outcome, and each commit pulse retires the head into one
 * registered BTB update.
 */
`include "fetch_params.svh"

module CtrlQueue (
  input  logic                                      clk,
  input  logic                                      rst_i,
  input  logic                                      stall_i,
  input  logic                                      recoverFlag_i,
  input  logic                                      fs1Ready_i,
  input  fetchPkg::fetchMask_t                      pushMask_i,
  input  fetchPkg::pc_t [`FETCH_BANDWIDTH-1:0]       slotPc_i,
  input  fetchPkg::ctrlType_t [`FETCH_BANDWIDTH-1:0] slotType_i,
  output ctiPkg::ctiqTag_t [`FETCH_BANDWIDTH-1:0]    slotTag_o,
  input  ctiPkg::ctiqTag_t                          resolveIndex_i,
  input  fetchPkg::pc_t                             resolveTarget_i,
  input  logic                                      resolveTaken_i,
  input  logic                                      resolveValid_i,
  input  logic                                      flagRecoverEX_i,
  input  logic                                      commit_i,
  output ctiPkg::btbUpdate_t                        btbUpdate_o,
  output logic                                      full_o
);

  ctiPkg::ctiqEntry_t queue [`CTIQ_DEPTH];
  ctiPkg::ctiqTag_t   head;
  ctiPkg::ctiqTag_t   tail;
  ctiPkg::ctiqTag_t   pushTail;
  logic [`CTIQ_LOG:0] count;
  logic [`CTIQ_LOG:0] pushNum;
  logic [`CTIQ_LOG:0] popNum;
  logic [`CTIQ_LOG:0] exSpan;
  logic               pushEn;
  logic               popEn;

  // each slot gets the tail plus the number of pushed slots ahead of it.
  always_comb begin
    pushTail = tail;
    pushNum  = '0;
    for (int i = 0; i < `FETCH_BANDWIDTH; i++) begin
      slotTag_o[i] = pushTail;
      if (pushMask_i[`FETCH_BANDWIDTH-1-i]) begin
        pushTail = pushTail + 1'b1;
        pushNum  = pushNum + 1'b1;
      end
    end
  end

  // full means a whole bundle of CTIs might no longer fit.
  assign full_o = count > (`CTIQ_LOG+1)'(`CTIQ_DEPTH - `FETCH_BANDWIDTH);
  assign pushEn = fs1Ready_i & ~stall_i & ~recoverFlag_i & ~full_o;
  assign popEn  = commit_i & (count != '0) & ~recoverFlag_i;
  assign popNum = {{`CTIQ_LOG{1'b0}}, popEn};

  // entries from the head up to the mispredicted CTI survive an execute recovery.
  assign exSpan = {1'b0, ctiPkg::ctiqTag_t'(resolveIndex_i - head)} + 1'b1;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else if (recoverFlag_i) begin
      tail  <= head;
      count <= '0;
    end else begin
      head <= head + popEn;
      if (flagRecoverEX_i) begin
        tail  <= resolveIndex_i + 1'b1;
        count <= exSpan - popNum;
      end else if (pushEn) begin
        tail  <= pushTail;
        count <= count + pushNum - popNum;
      end else begin
        count <= count - popNum;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (pushEn && !flagRecoverEX_i) begin
      for (int i = 0; i < `FETCH_BANDWIDTH; i++) begin
        if (pushMask_i[`FETCH_BANDWIDTH-1-i]) begin
          queue[slotTag_o[i]] <= '{pc: slotPc_i[i], ctrlType: slotType_i[i],
                                   target: '0, taken: 1'b0, resolved: 1'b0};
        end
      end
    end
    if (resolveValid_i) begin
      queue[resolveIndex_i].target   <= resolveTarget_i;
      queue[resolveIndex_i].taken    <= resolveTaken_i;
      queue[resolveIndex_i].resolved <= 1'b1;
    end
  end

  // an entry that was never resolved retires as not taken.
  always_ff @(posedge clk) begin
    if (rst_i) begin
      btbUpdate_o.en <= 1'b0;
    end else begin
      btbUpdate_o.en <= popEn;
    end
    if (popEn) begin
      btbUpdate_o.pc       <= queue[head].pc;
      btbUpdate_o.target   <= queue[head].target;
      btbUpdate_o.ctrlType <= queue[head].ctrlType;
      btbUpdate_o.dir      <= queue[head].taken & queue[head].resolved;
    end
  end

endmodule

/* source/FetchStage2.sv */
/*
 * Fetch stage 2 of the four-wide front end. Pre-decodes the fetched bundle,
 * checks it against the BTB, trims slots after the first control transfer
 * and raises a decode redirect on a BTB miss. Packed arrays index by slot.
 */
`include "fetch_params.svh"

module FetchStage2 (
  input  logic                                        clk,
  input  logic                                        rst_i,
  input  logic                                        stall_i,
  input  logic                                        recoverFlag_i,
  input  logic                                        fs1Ready_i,
  input  fetchPkg::pc_t                               pc_i,
  input  fetchPkg::instruction_t [`FETCH_BANDWIDTH-1:0] bundle_i,
  input  fetchPkg::btbSlot_t [`FETCH_BANDWIDTH-1:0]     btb_i,
  input  fetchPkg::pc_t                               rasAddr_i,
  input  ctiPkg::ctiqTag_t                            resolveIndex_i,
  input  fetchPkg::pc_t                               resolveTarget_i,
  input  logic                                        resolveTaken_i,
  input  logic                                        resolveValid_i,
  input  logic                                        flagRecoverEX_i,
  input  logic                                        commit_i,
  output fetchPkg::fetchMask_t                        instValid_o,
  output fetchPkg::instPacket_t [`FETCH_BANDWIDTH-1:0]  instPacket_o,
  output fetchPkg::idRedirect_t                       redirect_o,
  output ctiPkg::btbUpdate_t                          btbUpdate_o,
  output logic                                        fs2Ready_o,
  output logic                                        ctiQueueFull_o
);

  fetchPkg::pc_t [`FETCH_BANDWIDTH-1:0]       slotPc;
  fetchPkg::pc_t [`FETCH_BANDWIDTH-1:0]       decTarget;
  fetchPkg::pc_t [`FETCH_BANDWIDTH-1:0]       pktTarget;
  fetchPkg::ctrlType_t [`FETCH_BANDWIDTH-1:0] ctrlType;
  ctiPkg::ctiqTag_t [`FETCH_BANDWIDTH-1:0]    slotTag;
  logic [`FETCH_BANDWIDTH-1:0]                isCtrl;
  logic [`FETCH_BANDWIDTH-1:0]                ctrlSlot;
  fetchPkg::fetchMask_t                       pushMask;
  fetchPkg::idRedirect_t                      redirect;
  logic                                       queueFull;

  for (genvar g = 0; g < `FETCH_BANDWIDTH; g++) begin : gSlot
    assign slotPc[g] = pc_i + fetchPkg::pc_t'(g * `INST_BYTES);

    PreDecode preDecode (
      .pc_i         (slotPc[g]),
      .instruction_i(bundle_i[g]),
      .prediction_i (btb_i[g].prediction),
      .btbTarget_i  (btb_i[g].target),
      .isCtrl_o     (isCtrl[g]),
      .ctrlType_o   (ctrlType[g]),
      .target_o     (decTarget[g])
    );

    // a not-taken conditional branch lets the bundle continue.
    assign ctrlSlot[g] = isCtrl[g] &
                         (btb_i[g].prediction | (ctrlType[g] != fetchPkg::CT_CBRANCH));
  end

  always_comb begin : validateBtb
    logic afterFirst;
    afterFirst  = 1'b0;
    instValid_o = '0;
    pushMask    = '0;
    redirect    = '0;
    for (int i = 0; i < `FETCH_BANDWIDTH; i++) begin
      pktTarget[i] = decTarget[i];
      if (!afterFirst) begin
        instValid_o[`FETCH_BANDWIDTH-1-i] = 1'b1;
        pushMask[`FETCH_BANDWIDTH-1-i]    = isCtrl[i];
        if (ctrlSlot[i]) begin
          afterFirst      = 1'b1;
          redirect.target = decTarget[i];
          redirect.callPc = slotPc[i];
          if (!btb_i[i].hit) begin
            redirect.recover = 1'b1;
            redirect.isCall  = ctrlType[i] == fetchPkg::CT_CALL;
            // the BTB target is meaningless on a miss, so a return uses the RAS.
            if (ctrlType[i] == fetchPkg::CT_RETURN) begin
              redirect.isReturn = 1'b1;
              redirect.target   = rasAddr_i;
              pktTarget[i]      = rasAddr_i;
            end
          end
        end
      end
      instPacket_o[i] = '{instruction: bundle_i[i], pc: slotPc[i], target: pktTarget[i],
                          ctiqTag: slotTag[i], prediction: btb_i[i].prediction};
    end
  end

  always_comb begin
    redirect_o         = redirect;
    redirect_o.recover = redirect.recover & ~stall_i & ~queueFull;
  end

  CtrlQueue ctiQueue (
    .clk            (clk),
    .rst_i          (rst_i),
    .stall_i        (stall_i),
    .recoverFlag_i  (recoverFlag_i),
    .fs1Ready_i     (fs1Ready_i),
    .pushMask_i     (pushMask),
    .slotPc_i       (slotPc),
    .slotType_i     (ctrlType),
    .slotTag_o      (slotTag),
    .resolveIndex_i (resolveIndex_i),
    .resolveTarget_i(resolveTarget_i),
    .resolveTaken_i (resolveTaken_i),
    .resolveValid_i (resolveValid_i),
    .flagRecoverEX_i(flagRecoverEX_i),
    .commit_i       (commit_i),
    .btbUpdate_o    (btbUpdate_o),
    .full_o         (queueFull)
  );

  assign ctiQueueFull_o = queueFull;
  assign fs2Ready_o     = fs1Ready_i & ~queueFull;

endmodule

/* source/PreDecode.sv */
/*
 * Pre-decode of one fetch slot. Flags control transfer instructions, returns
 * their control type and the direct target; purely combinational.
 */
`include "fetch_params.svh"

module PreDecode (
  input  fetchPkg::pc_t          pc_i,
  input  fetchPkg::instruction_t instruction_i,
  input  logic                   prediction_i,
  input  fetchPkg::pc_t          btbTarget_i,
  output logic                   isCtrl_o,
  output fetchPkg::ctrlType_t    ctrlType_o,
  output fetchPkg::pc_t          target_o
);

  logic [7:0]    opcode;
  logic [15:0]   offset;
  fetchPkg::pc_t fallThrough;
  fetchPkg::pc_t jumpTarget;
  fetchPkg::pc_t branchTarget;

  assign opcode = instruction_i[`SIZE_INSTRUCTION-1 -: 8];
  assign offset = instruction_i[15:0];

  assign fallThrough = pc_i + fetchPkg::pc_t'(`INST_BYTES);

  // region-relative jump, the index counts 8-byte instructions.
  assign jumpTarget = {pc_i[`SIZE_PC-1 -: 3], instruction_i[25:0], 3'b000};

  assign branchTarget = fallThrough + {{(`SIZE_PC-19){offset[15]}}, offset, 3'b000};

  always_comb begin
    isCtrl_o   = 1'b1;
    ctrlType_o = fetchPkg::CT_JUMP;
    target_o   = fallThrough;
    case (opcode)
      `OP_JUMP: target_o = jumpTarget;
      `OP_CALL: begin
        ctrlType_o = fetchPkg::CT_CALL;
        target_o   = jumpTarget;
      end
      // a return has no direct target, so the BTB's guess is kept.
      `OP_RETURN: begin
        ctrlType_o = fetchPkg::CT_RETURN;
        target_o   = btbTarget_i;
      end
      `OP_CBRANCH: begin
        ctrlType_o = fetchPkg::CT_CBRANCH;
        target_o   = prediction_i ? branchTarget : fallThrough;
      end
      default: isCtrl_o = 1'b0;
    endcase
  end

endmodule

/* source/ctiPkg.sv */
/*
 * Control queue types: the queue tag, one queue entry and the BTB update
 * produced when an entry retires.
 */
`include "fetch_params.svh"

package ctiPkg;

  typedef logic [`CTIQ_LOG-1:0] ctiqTag_t;

  typedef struct packed {
    fetchPkg::pc_t       pc;
    fetchPkg::ctrlType_t ctrlType;
    fetchPkg::pc_t       target;
    logic                taken;
    logic                resolved;
  } ctiqEntry_t;

  typedef struct packed {
    logic                en;
    fetchPkg::pc_t       pc;
    fetchPkg::pc_t       target;
    fetchPkg::ctrlType_t ctrlType;
    logic                dir;
  } btbUpdate_t;

endpackage

/* source/fetchPkg.sv */
/*
 * Fetch datapath types: PC and instruction words, control types, BTB slot
 * results, the per-slot instruction packet and the decode redirect.
 */
`include "fetch_params.svh"

package fetchPkg;

  typedef logic [`SIZE_PC-1:0] pc_t;
  typedef logic [`SIZE_INSTRUCTION-1:0] instruction_t;

  typedef enum logic [1:0] {
    CT_RETURN  = 2'd0,
    CT_CALL    = 2'd1,
    CT_JUMP    = 2'd2,
    CT_CBRANCH = 2'd3
  } ctrlType_t;

  typedef struct packed {
    logic hit;
    pc_t  target;
    logic prediction;
  } btbSlot_t;

  // the tag width is spelled out here since the queue package depends on this one.
  typedef struct packed {
    instruction_t        instruction;
    pc_t                 pc;
    pc_t                 target;
    logic [`CTIQ_LOG-1:0] ctiqTag;
    logic                prediction;
  } instPacket_t;

  typedef struct packed {
    logic recover;
    logic isReturn;
    logic isCall;
    pc_t  target;
    pc_t  callPc;
  } idRedirect_t;

  // one bit per slot, slot 0 in the most significant bit.
  typedef logic [`FETCH_BANDWIDTH-1:0] fetchMask_t;

endpackage

/* source/fetch_params.svh */
/*
 * Width, bandwidth and opcode constants shared by the fetch stage 2 RTL and
 * its testbench. Include wherever one of these macros is referenced.
 */
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

`define SIZE_PC 32
`define SIZE_INSTRUCTION 64

// four instructions arrive per fetch bundle.
`define FETCH_BANDWIDTH 4
`define INST_BYTES 8

// control queue geometry.
`define CTIQ_DEPTH 16
`define CTIQ_LOG 4

// opcode field is instruction bits 63 to 56.
`define OP_JUMP 8'h01
`define OP_CALL 8'h02
`define OP_RETURN 8'h03
`define OP_CBRANCH 8'h05

`endif
